// ==== rv_fetch_pkg.sv ====
package rv_fetch_pkg;

  // basic widths of the fetch side
  typedef logic [63:0] addr_t;
  typedef logic [63:0] data_t;
  typedef logic [31:0] inst_t;
  // one strobe bit per byte of data_t
  typedef logic [7:0]  mask_t;
  typedef logic [3:0]  bus_id_t;

  // transaction tags
  localparam bus_id_t FETCH_ID = 4'd1;
  localparam bus_id_t MEM_ID   = 4'd2;

  // addi x0, x0, 0
  localparam inst_t NOP_INST = 32'h0000_0013;

  // granted request, arbiter to master
  typedef struct packed {
    logic    valid;
    logic    we;
    addr_t   addr;
    data_t   wdata;
    mask_t   wmask;
    bus_id_t id;
  } bus_req_t;

  // completion, done is a single-cycle pulse
  typedef struct packed {
    logic    done;
    data_t   rdata;
    bus_id_t id;
  } bus_rsp_t;

  // AXI channels, ready bits travel separately
  typedef struct packed {logic valid; addr_t addr; bus_id_t id;} axi_ar_t;
  typedef struct packed {logic valid; data_t data; logic last;} axi_r_t;
  typedef struct packed {logic valid; addr_t addr;} axi_aw_t;
  typedef struct packed {logic valid; data_t data; mask_t strb; logic last;} axi_w_t;

endpackage

// ==== pc_gen.sv ====
`timescale 1ns/100ps

module pc_gen #(
  parameter rv_fetch_pkg::addr_t BOOT_PC = 64'h0000_0000_8000_0000
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 stall_i,
  input  logic                 redirect_i,
  input  rv_fetch_pkg::addr_t  redirect_pc_i,
  input  logic                 fetch_grant_i,
  input  rv_fetch_pkg::bus_rsp_t rsp_i,
  output logic                 fetch_req_o,
  output rv_fetch_pkg::addr_t  fetch_addr_o,
  output logic                 deliver_o,
  output rv_fetch_pkg::addr_t  pc_o
);
  import rv_fetch_pkg::*;

  addr_t pc_q;
  logic  outstanding_q;
  logic  discard_q;
  logic  fetch_done;

  // completion of our own fetch
  assign fetch_done = rsp_i.done && (rsp_i.id == FETCH_ID);

  // request as a level, dropped once the arbiter took it
  assign fetch_req_o  = !stall_i && !outstanding_q;
  assign fetch_addr_o = pc_q;

  // a redirect in the done cycle kills that fetch as well
  assign deliver_o = fetch_done && !discard_q && !redirect_i;
  // pc holds while the fetch is in flight, so this is the fetched address
  assign pc_o      = pc_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q          <= BOOT_PC;
      outstanding_q <= 1'b0;
      discard_q     <= 1'b0;
    end else begin
      // redirect wins over sequential advance
      if (redirect_i) begin
        pc_q <= redirect_pc_i;
      end else if (deliver_o) begin
        pc_q <= pc_q + 64'd4;
      end
      // grant and done never coincide, only one transaction on the bus
      if (fetch_grant_i) begin
        outstanding_q <= 1'b1;
      end else if (fetch_done) begin
        outstanding_q <= 1'b0;
      end
      // mark a fetch that is still owed to us but no longer wanted
      if (redirect_i && ((outstanding_q && !fetch_done) || fetch_grant_i)) begin
        discard_q <= 1'b1;
      end else if (fetch_done) begin
        discard_q <= 1'b0;
      end
    end
  end

endmodule

// ==== bus_arbiter.sv ====
`timescale 1ns/100ps

module bus_arbiter (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   fetch_req_i,
  input  rv_fetch_pkg::addr_t    fetch_addr_i,
  input  logic                   mem_valid_i,
  input  logic                   mem_we_i,
  input  rv_fetch_pkg::addr_t    mem_addr_i,
  input  rv_fetch_pkg::data_t    mem_wdata_i,
  input  rv_fetch_pkg::mask_t    mem_wmask_i,
  input  rv_fetch_pkg::bus_rsp_t rsp_i,
  output logic                   fetch_grant_o,
  output rv_fetch_pkg::bus_req_t req_o
);
  import rv_fetch_pkg::*;

  bus_req_t req_q;
  // one dead cycle after each done
  logic     gap_q;
  logic     idle;
  logic     take_mem;
  logic     take_fetch;
  logic     finish;

  assign idle       = !req_q.valid && !gap_q;
  // data side has priority over fetch
  assign take_mem   = idle && mem_valid_i;
  assign take_fetch = idle && !mem_valid_i && fetch_req_i;
  assign finish     = req_q.valid && rsp_i.done;

  assign fetch_grant_o = take_fetch;
  assign req_o         = req_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q <= '0;
      gap_q <= 1'b0;
    end else begin
      gap_q <= finish;
      if (finish) begin
        req_q.valid <= 1'b0;
      end else if (take_mem) begin
        req_q <= '{valid: 1'b1, we: mem_we_i, addr: mem_addr_i,
                   wdata: mem_wdata_i, wmask: mem_wmask_i, id: MEM_ID};
      end else if (take_fetch) begin
        // fetches are always reads
        req_q <= '{valid: 1'b1, we: 1'b0, addr: fetch_addr_i,
                   wdata: '0, wmask: '0, id: FETCH_ID};
      end
    end
  end

endmodule

// ==== axi_master.sv ====
`timescale 1ns/100ps

module axi_master (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rv_fetch_pkg::bus_req_t req_i,
  output rv_fetch_pkg::bus_rsp_t rsp_o,
  output rv_fetch_pkg::axi_ar_t  ar_o,
  input  logic                   ar_ready_i,
  input  rv_fetch_pkg::axi_r_t   r_i,
  output logic                   r_ready_o,
  output rv_fetch_pkg::axi_aw_t  aw_o,
  input  logic                   aw_ready_i,
  output rv_fetch_pkg::axi_w_t   w_o,
  input  logic                   w_ready_i,
  input  logic                   b_valid_i,
  output logic                   b_ready_o
);
  import rv_fetch_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_AR,
    S_R,
    S_W,
    S_B,
    S_DONE
  } state_e;

  state_e  state_q;
  state_e  state_d;
  logic    aw_done_q;
  logic    w_done_q;
  logic    aw_hs;
  logic    w_hs;
  logic    r_hs;
  data_t   rdata_q;
  bus_id_t id_q;

  assign aw_hs = aw_o.valid && aw_ready_i;
  assign w_hs  = w_o.valid && w_ready_i;
  assign r_hs  = r_i.valid && r_ready_o;

  // channel outputs straight from state, request fields held by arbiter
  assign ar_o = '{valid: state_q == S_AR, addr: req_i.addr, id: req_i.id};
  assign aw_o = '{valid: (state_q == S_W) && !aw_done_q, addr: req_i.addr};
  assign w_o  = '{valid: (state_q == S_W) && !w_done_q, data: req_i.wdata,
                  strb: req_i.wmask, last: 1'b1};
  assign r_ready_o = state_q == S_R;
  assign b_ready_o = state_q == S_B;
  assign rsp_o     = '{done: state_q == S_DONE, rdata: rdata_q, id: id_q};

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (req_i.valid) begin
          state_d = req_i.we ? S_W : S_AR;
        end
      end
      S_AR: begin
        if (ar_ready_i) begin
          state_d = S_R;
        end
      end
      // single beat, but still wait for last
      S_R: begin
        if (r_hs && r_i.last) begin
          state_d = S_DONE;
        end
      end
      // aw and w may finish in different cycles
      S_W: begin
        if ((aw_done_q || aw_hs) && (w_done_q || w_hs)) begin
          state_d = S_B;
        end
      end
      S_B: begin
        if (b_valid_i) begin
          state_d = S_DONE;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= S_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      state_q   <= state_d;
      // remember each finished write channel until we leave S_W
      aw_done_q <= (state_d == S_W) && (aw_done_q || aw_hs);
      w_done_q  <= (state_d == S_W) && (w_done_q || w_hs);
    end
  end

  // response payload
  always_ff @(posedge clk) begin
    if ((state_q == S_IDLE) && req_i.valid) begin
      id_q <= req_i.id;
    end
    if (r_hs) begin
      rdata_q <= r_i.data;
    end
  end

endmodule

// ==== axi_mem_slave.sv ====
`timescale 1ns/100ps

module axi_mem_slave #(
  parameter int MEM_WORDS = 64
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  rv_fetch_pkg::axi_ar_t ar_i,
  output logic                  ar_ready_o,
  output rv_fetch_pkg::axi_r_t  r_o,
  input  logic                  r_ready_i,
  input  rv_fetch_pkg::axi_aw_t aw_i,
  output logic                  aw_ready_o,
  input  rv_fetch_pkg::axi_w_t  w_i,
  output logic                  w_ready_o,
  output logic                  b_valid_o,
  input  logic                  b_ready_i
);
  import rv_fetch_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);

  // word index inside the scratch memory
  typedef logic [IDX_W-1:0] idx_t;

  data_t mem_q [MEM_WORDS];
  data_t r_data_q;
  logic  r_valid_q;
  logic  b_valid_q;
  logic  idle;
  logic  rd_acc;
  logic  wr_acc;
  idx_t  rd_idx;
  idx_t  wr_idx;

  // one transaction at a time
  assign idle   = !r_valid_q && !b_valid_q;
  assign rd_acc = idle && ar_i.valid;
  // write only with both address and single-beat data present
  assign wr_acc = idle && !ar_i.valid && aw_i.valid && w_i.valid && w_i.last;

  // address bits 3 up, wraps modulo MEM_WORDS
  assign rd_idx = ar_i.addr[3 +: IDX_W];
  assign wr_idx = aw_i.addr[3 +: IDX_W];

  assign ar_ready_o = idle;
  assign aw_ready_o = idle;
  assign w_ready_o  = idle;
  assign r_o        = '{valid: r_valid_q, data: r_data_q, last: 1'b1};
  assign b_valid_o  = b_valid_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      r_valid_q <= 1'b0;
      b_valid_q <= 1'b0;
      // low half holds the byte address, high half its inverse
      for (int k = 0; k < MEM_WORDS; k++) begin
        mem_q[k] <= {~(32'(k * 8)), 32'(k * 8)};
      end
    end else begin
      // valids held until the master takes them
      if (rd_acc) begin
        r_valid_q <= 1'b1;
      end else if (r_ready_i) begin
        r_valid_q <= 1'b0;
      end
      if (wr_acc) begin
        b_valid_q <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_q <= 1'b0;
      end
      // byte merge under strobe
      if (wr_acc) begin
        for (int b = 0; b < 8; b++) begin
          if (w_i.strb[b]) begin
            mem_q[wr_idx][8*b +: 8] <= w_i.data[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_acc) begin
      r_data_q <= mem_q[rd_idx];
    end
  end

endmodule

// ==== if_stage.sv ====
`timescale 1ns/100ps

module if_stage #(
  parameter rv_fetch_pkg::addr_t BOOT_PC = 64'h0000_0000_8000_0000,
  parameter int MEM_WORDS = 64
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                stall_i,
  input  logic                redirect_i,
  input  rv_fetch_pkg::addr_t redirect_pc_i,
  input  logic                mem_valid_i,
  input  logic                mem_we_i,
  input  rv_fetch_pkg::addr_t mem_addr_i,
  input  rv_fetch_pkg::data_t mem_wdata_i,
  input  rv_fetch_pkg::mask_t mem_wmask_i,
  output logic                inst_valid_o,
  output rv_fetch_pkg::inst_t inst_o,
  output rv_fetch_pkg::addr_t pc_o,
  output logic                mem_done_o,
  output rv_fetch_pkg::data_t mem_rdata_o
);
  import rv_fetch_pkg::*;

  logic     fetch_req;
  addr_t    fetch_addr;
  logic     fetch_grant;
  logic     deliver;
  addr_t    fetch_pc;
  bus_req_t bus_req;
  bus_rsp_t bus_rsp;
  axi_ar_t  ar;
  logic     ar_ready;
  axi_r_t   r;
  logic     r_ready;
  axi_aw_t  aw;
  logic     aw_ready;
  axi_w_t   w;
  logic     w_ready;
  logic     b_valid;
  logic     b_ready;
  inst_t    inst_sel;
  logic     mem_rsp;

  pc_gen #(
    .BOOT_PC (BOOT_PC)
  ) u_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .fetch_grant_i (fetch_grant),
    .rsp_i         (bus_rsp),
    .fetch_req_o   (fetch_req),
    .fetch_addr_o  (fetch_addr),
    .deliver_o     (deliver),
    .pc_o          (fetch_pc)
  );

  bus_arbiter u_bus_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_req_i   (fetch_req),
    .fetch_addr_i  (fetch_addr),
    .mem_valid_i   (mem_valid_i),
    .mem_we_i      (mem_we_i),
    .mem_addr_i    (mem_addr_i),
    .mem_wdata_i   (mem_wdata_i),
    .mem_wmask_i   (mem_wmask_i),
    .rsp_i         (bus_rsp),
    .fetch_grant_o (fetch_grant),
    .req_o         (bus_req)
  );

  axi_master u_axi_master (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (bus_req),
    .rsp_o      (bus_rsp),
    .ar_o       (ar),
    .ar_ready_i (ar_ready),
    .r_i        (r),
    .r_ready_o  (r_ready),
    .aw_o       (aw),
    .aw_ready_i (aw_ready),
    .w_o        (w),
    .w_ready_i  (w_ready),
    .b_valid_i  (b_valid),
    .b_ready_o  (b_ready)
  );

  axi_mem_slave #(
    .MEM_WORDS (MEM_WORDS)
  ) u_axi_mem_slave (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_i       (ar),
    .ar_ready_o (ar_ready),
    .r_o        (r),
    .r_ready_i  (r_ready),
    .aw_i       (aw),
    .aw_ready_o (aw_ready),
    .w_i        (w),
    .w_ready_o  (w_ready),
    .b_valid_o  (b_valid),
    .b_ready_i  (b_ready)
  );

  // pc bit 2 picks the 32-bit half of the bus word
  assign inst_sel = fetch_pc[2] ? bus_rsp.rdata[63:32] : bus_rsp.rdata[31:0];
  assign mem_rsp  = bus_rsp.done && (bus_rsp.id == MEM_ID);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inst_valid_o <= 1'b0;
      inst_o       <= NOP_INST;
      mem_done_o   <= 1'b0;
    end else begin
      inst_valid_o <= deliver;
      // nop whenever nothing is delivered
      inst_o       <= deliver ? inst_sel : NOP_INST;
      mem_done_o   <= mem_rsp;
    end
  end

  // captured alongside the valid pulses
  always_ff @(posedge clk) begin
    if (deliver) begin
      pc_o <= fetch_pc;
    end
    if (mem_rsp) begin
      mem_rdata_o <= bus_rsp.rdata;
    end
  end

endmodule

// ==== tb_if_stage.sv ====
`timescale 1ns/100ps

module tb_if_stage;
  import rv_fetch_pkg::*;

  localparam addr_t BOOT_PC      = 64'h0000_0000_8000_0000;
  localparam int    MEM_WORDS    = 64;
  localparam int    INST_TIMEOUT = 50;
  localparam int    MEM_TIMEOUT  = 50;
  // cycles watched while the stage is stalled
  localparam int    STALL_WINDOW = 30;

  logic  clk;
  logic  rst_n;
  logic  stall_i;
  logic  redirect_i;
  addr_t redirect_pc_i;
  logic  mem_valid_i;
  logic  mem_we_i;
  addr_t mem_addr_i;
  data_t mem_wdata_i;
  mask_t mem_wmask_i;
  logic  inst_valid_o;
  inst_t inst_o;
  addr_t pc_o;
  logic  mem_done_o;
  data_t mem_rdata_o;

  // reference copy of the scratch memory
  data_t       ref_mem [MEM_WORDS];
  logic [31:0] lfsr_q;
  // pc of the next expected delivery
  addr_t       exp_pc;

  if_stage #(
    .BOOT_PC   (BOOT_PC),
    .MEM_WORDS (MEM_WORDS)
  ) UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .mem_valid_i   (mem_valid_i),
    .mem_we_i      (mem_we_i),
    .mem_addr_i    (mem_addr_i),
    .mem_wdata_i   (mem_wdata_i),
    .mem_wmask_i   (mem_wmask_i),
    .inst_valid_o  (inst_valid_o),
    .inst_o        (inst_o),
    .pc_o          (pc_o),
    .mem_done_o    (mem_done_o),
    .mem_rdata_o   (mem_rdata_o)
  );

  always #50 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_inst(input string name, input inst_t exp, input inst_t act);
    if (exp !== act) abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (exp !== act) abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act) abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[62:0], lfsr_q[31]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // low half byte address, high half its inverse
  function automatic data_t reset_word(input int k);
    logic [31:0] byte_addr;
    byte_addr = 32'(k * 8);
    return {~byte_addr, byte_addr};
  endfunction

  function automatic int word_idx(input addr_t a);
    return int'((a >> 3) % MEM_WORDS);
  endfunction

  function automatic inst_t ref_inst(input addr_t pc);
    data_t w;
    w = ref_mem[word_idx(pc)];
    return pc[2] ? w[63:32] : w[31:0];
  endfunction

  task automatic merge_ref(input addr_t a, input data_t d, input mask_t m);
    for (int b = 0; b < 8; b++) begin
      if (m[b]) ref_mem[word_idx(a)][8*b +: 8] = d[8*b +: 8];
    end
  endtask

  // inputs change 10 ns after the edge, outputs are read there too
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic wait_inst(input string name);
    int n;
    n = 0;
    next_cycle();
    while (inst_valid_o !== 1'b1) begin
      n++;
      if (n > INST_TIMEOUT) abort_run($sformatf("%s: inst_valid_o never pulsed", name));
      next_cycle();
    end
  endtask

  // next delivery must be exp_pc with its model instruction
  task automatic next_inst(input string name);
    wait_inst(name);
    check_addr(name, exp_pc, pc_o);
    check_inst(name, ref_inst(exp_pc), inst_o);
    exp_pc = exp_pc + 64'd4;
  endtask

  task automatic redirect_to(input addr_t target);
    redirect_i    = 1'b1;
    redirect_pc_i = target;
    next_cycle();
    redirect_i = 1'b0;
    exp_pc     = target;
    // delivery is masked during the redirect cycle
    if (inst_valid_o !== 1'b0) abort_run("instruction delivered during a redirect cycle");
  endtask

  // level request held until mem_done_o
  task automatic mem_access(input string name, input logic we, input addr_t a,
                            input data_t d, input mask_t m);
    int n;
    mem_valid_i = 1'b1;
    mem_we_i    = we;
    mem_addr_i  = a;
    mem_wdata_i = d;
    mem_wmask_i = m;
    n = 0;
    next_cycle();
    while (mem_done_o !== 1'b1) begin
      n++;
      if (n > MEM_TIMEOUT) abort_run($sformatf("%s: mem_done_o never pulsed", name));
      next_cycle();
    end
    mem_valid_i = 1'b0;
    mem_we_i    = 1'b0;
    if (we) begin
      merge_ref(a, d, m);
    end else begin
      check_data(name, ref_mem[word_idx(a)], mem_rdata_o);
    end
  endtask

  task automatic test_reset();
    if (inst_valid_o !== 1'b0) abort_run("inst_valid_o not low after reset");
    if (mem_done_o !== 1'b0) abort_run("mem_done_o not low after reset");
    check_inst("reset nop", NOP_INST, inst_o);
    exp_pc = BOOT_PC;
    next_inst("reset first fetch");
  endtask

  task automatic test_sequential();
    for (int i = 0; i < 20; i++) begin
      next_inst($sformatf("sequential %0d", i));
    end
  endtask

  task automatic test_redirect(input addr_t target);
    next_inst("redirect sync");
    // gap cycle, then grant, so the fetch of exp_pc is in flight
    next_cycle();
    next_cycle();
    redirect_to(target);
    next_inst("redirect target");
    next_inst("redirect target plus 4");
    // redirect lands in the done cycle of the next fetch
    repeat (5) next_cycle();
    redirect_to(target + 64'h40);
    next_inst("redirect on done");
  endtask

  task automatic test_stall();
    int seen;
    seen = 0;
    next_inst("stall sync");
    next_cycle();
    next_cycle();
    stall_i = 1'b1;
    for (int i = 0; i < STALL_WINDOW; i++) begin
      next_cycle();
      if (inst_valid_o === 1'b1) begin
        check_addr("stall in flight", exp_pc, pc_o);
        check_inst("stall in flight", ref_inst(exp_pc), inst_o);
        exp_pc = exp_pc + 64'd4;
        seen++;
      end else begin
        check_inst("stall idle nop", NOP_INST, inst_o);
      end
    end
    if (seen > 1) abort_run("more than one delivery while stalled");
    check_addr("stall pc hold", exp_pc - 64'd4, pc_o);
    stall_i = 1'b0;
    next_inst("stall release");
  endtask

  task automatic test_mem_stage();
    addr_t a;
    a = BOOT_PC + 64'h40;
    mem_access("mem write", 1'b1, a, 64'h1122_3344_5566_7788, 8'b1010_0101);
    mem_access("mem read", 1'b0, a, '0, '0);
    // fetch the merged word as two instructions
    redirect_to(a);
    next_inst("mem fetch low");
    next_inst("mem fetch high");
  endtask

  task automatic test_random();
    logic [63:0] v;
    addr_t       a;
    data_t       d;
    mask_t       m;
    logic        we;
    for (int i = 0; i < 16; i++) begin
      // only 8 words, so reads often hit earlier writes
      take_bits(3, v);
      a = BOOT_PC + (v << 3);
      take_bits(1, v);
      we = v[0];
      d  = '0;
      m  = '0;
      if (we) begin
        take_bits(64, v);
        d = v;
        take_bits(8, v);
        m = v[7:0];
      end
      mem_access($sformatf("random %0d", i), we, a, d, m);
    end
    redirect_to(BOOT_PC);
    for (int i = 0; i < 4; i++) begin
      next_inst($sformatf("random fetch %0d", i));
    end
  endtask

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    stall_i       = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    mem_valid_i   = 1'b0;
    mem_we_i      = 1'b0;
    mem_addr_i    = '0;
    mem_wdata_i   = '0;
    mem_wmask_i   = '0;
    lfsr_q        = 32'h5eab;
    exp_pc        = BOOT_PC;
    for (int k = 0; k < MEM_WORDS; k++) begin
      ref_mem[k] = reset_word(k);
    end
    repeat (3) @(posedge clk);
    #10;
    rst_n = 1'b1;
    test_reset();
    test_sequential();
    test_redirect(BOOT_PC + 64'h104);
    test_stall();
    test_mem_stage();
    test_random();
    $display("No errors");
    $finish;
  end

endmodule

// ==== project.f ====
rv_fetch_pkg.sv
pc_gen.sv
bus_arbiter.sv
axi_master.sv
axi_mem_slave.sv
if_stage.sv
tb_if_stage.sv

// ==== Bender.yml ====
package:
  name: rv_fetch

sources:
  - rv_fetch_pkg.sv
  - pc_gen.sv
  - bus_arbiter.sv
  - axi_master.sv
  - axi_mem_slave.sv
  - if_stage.sv
  - target: simulation
    files:
      - tb_if_stage.sv
